// File: filelist.f
+incdir+rtl
rtl/pacman_pkg.sv
rtl/tilt_decoder.sv
rtl/pacman_mover.sv
rtl/sprite_window.sv
rtl/pacman_controller.sv
tb/pacman_controller_properties.sv
tb/pacman_controller_tb.sv

// File: rtl/pacman_config.svh
`ifndef PACMAN_CONFIG_SVH
`define PACMAN_CONFIG_SVH

// ==============================
// Board edges on the raster
// ==============================
`define H_BOARD_ON          200
`define H_BOARD_OFF         760

// ==============================
// Sprite size and start corner
// ==============================
`define H_SPRITE_SIZE       34
`define V_SPRITE_SIZE       34
`define H_START             463
`define V_START             500
`define TUNNEL_ROW_OFFSET   180     // Tunnel row sits this far above start
`define TILE_CENTER_OFFSET  17      // Corner to centre dot

// Flat yellow, RRRGGGBB
`define SPRITE_COLOUR       8'hfc

// Raster counter widths
`define H_WIDTH             11
`define V_WIDTH             10

`endif

// File: rtl/pacman_controller.sv
`timescale 1ns/100ps
`default_nettype none

module pacman_controller
(
	input  wire                          clk,
	input  wire                          reset,
	input  wire [15:0]                   x_axis,
	input  wire [15:0]                   y_axis,
	input  wire                          pause,
	input  wire                          stall,
	input  wire                          hz_enable,
	input  wire                          pacman_dead,
	input  wire                          end_of_game,
	input  wire pacman_pkg::dir_flags_t  limits,
	input  wire pacman_pkg::raster_pos_t raster,
	output pacman_pkg::dir_flags_t       heading_onehot,
	output pacman_pkg::sprite_pos_t      tile_center,
	output logic                         pacman_en,
	output logic                         waka,
	output pacman_pkg::pixel_t           pacman_pixel
);

	import pacman_pkg::*;

	dir_flags_t  tilt;     // Registered tilt requests
	sprite_pos_t pos;      // Sprite corner

	// ==============================
	// Tilt, movement, raster window
	// ==============================
	tilt_decoder tilt_decoder_inst
	(
		.clk    (clk),
		.reset  (reset),
		.x_axis (x_axis),
		.y_axis (y_axis),
		.tilt   (tilt)
	);

	pacman_mover pacman_mover_inst
	(
		.clk            (clk),
		.reset          (reset),
		.hz_enable      (hz_enable),
		.pause          (pause),
		.stall          (stall),
		.pacman_dead    (pacman_dead),
		.end_of_game    (end_of_game),
		.tilt           (tilt),
		.limits         (limits),
		.pos            (pos),
		.tile_center    (tile_center),
		.heading_onehot (heading_onehot),
		.waka           (waka)
	);

	sprite_window sprite_window_inst
	(
		.raster       (raster),
		.pos          (pos),
		.end_of_game  (end_of_game),
		.pacman_en    (pacman_en),
		.pacman_pixel (pacman_pixel)
	);

endmodule

`default_nettype wire

// File: rtl/pacman_mover.sv
`timescale 1ns/100ps
`default_nettype none

`include "pacman_config.svh"

module pacman_mover
(
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      hz_enable,       // Step strobe
	input  wire                      pause,           // User pause
	input  wire                      stall,           // System pause
	input  wire                      pacman_dead,
	input  wire                      end_of_game,
	input  wire pacman_pkg::dir_flags_t tilt,         // Requested turns
	input  wire pacman_pkg::dir_flags_t limits,       // 1 means open
	output pacman_pkg::sprite_pos_t  pos,
	output pacman_pkg::sprite_pos_t  tile_center,
	output pacman_pkg::dir_flags_t   heading_onehot,
	output logic                     waka
);

	import pacman_pkg::*;

	localparam int HW = `H_WIDTH;
	localparam int VW = `V_WIDTH;

	localparam logic [HW-1:0] H_START_POS  = HW'(`H_START);
	localparam logic [VW-1:0] V_START_POS  = VW'(`V_START);
	localparam logic [VW-1:0] V_TUNNEL     = VW'(`V_START - `TUNNEL_ROW_OFFSET);
	localparam logic [HW-1:0] H_WRAP_RIGHT = HW'(`H_BOARD_OFF - `H_SPRITE_SIZE);
	localparam logic [HW-1:0] H_WRAP_LEFT  = HW'(`H_BOARD_ON);
	localparam logic [HW-1:0] H_ENTER_LEFT = HW'(`H_BOARD_ON + 1);
	localparam logic [HW-1:0] H_ENTER_RIGHT = HW'(`H_BOARD_OFF - 1 - `H_SPRITE_SIZE);
	localparam logic [HW-1:0] H_TILE_OFF   = HW'(`TILE_CENTER_OFFSET);
	localparam logic [VW-1:0] V_TILE_OFF   = VW'(`TILE_CENTER_OFFSET);

	heading_t    heading;
	heading_t    next_heading;
	sprite_pos_t next_pos;
	dir_flags_t  turn_ok;          // Requests that are open and not the heading
	logic        moving;
	logic        step;

	assign step = hz_enable && !pause && !stall;

	// ==============================
	// Heading decode
	// ==============================
	always_comb
	begin
		heading_onehot = '0;
		case (heading)
			HEAD_RIGHT: heading_onehot.right = 1'b1;
			HEAD_LEFT:  heading_onehot.left  = 1'b1;
			HEAD_DOWN:  heading_onehot.down  = 1'b1;
			HEAD_UP:    heading_onehot.up    = 1'b1;
		endcase
	end

	assign turn_ok = tilt & limits & ~heading_onehot;
	assign moving  = (|turn_ok) || (|(limits & heading_onehot));
	assign waka    = moving;    // Mouth stops while blocked

	// Turn priority up, down, left, right
	always_comb
	begin
		next_heading = heading;
		if (turn_ok.up)
			next_heading = HEAD_UP;
		else if (turn_ok.down)
			next_heading = HEAD_DOWN;
		else if (turn_ok.left)
			next_heading = HEAD_LEFT;
		else if (turn_ok.right)
			next_heading = HEAD_RIGHT;
	end

	// One pixel along the new heading, tunnel on the side edges
	always_comb
	begin
		next_pos = pos;
		if (moving)
		begin
			case (next_heading)
				HEAD_UP:   next_pos.v = pos.v - 1'b1;
				HEAD_DOWN: next_pos.v = pos.v + 1'b1;
				HEAD_LEFT:
				begin
					if (pos.h == H_WRAP_LEFT)
					begin
						next_pos.h = H_ENTER_RIGHT;
						next_pos.v = V_TUNNEL;
					end
					else
						next_pos.h = pos.h - 1'b1;
				end
				HEAD_RIGHT:
				begin
					if (pos.h == H_WRAP_RIGHT)
					begin
						next_pos.h = H_ENTER_LEFT;
						next_pos.v = V_TUNNEL;
					end
					else
						next_pos.h = pos.h + 1'b1;
				end
			endcase
		end
	end

	// ==============================
	// State registers
	// ==============================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			heading <= HEAD_RIGHT;
			pos.h   <= H_START_POS;
			pos.v   <= V_START_POS;
		end
		else if (pacman_dead || end_of_game)  // Back to start, wins over a step
		begin
			heading <= HEAD_RIGHT;
			pos.h   <= H_START_POS;
			pos.v   <= V_START_POS;
		end
		else if (step)
		begin
			heading <= next_heading;
			pos     <= next_pos;
		end
	end

	assign tile_center.h = pos.h + H_TILE_OFF;
	assign tile_center.v = pos.v + V_TILE_OFF;

endmodule

`default_nettype wire

// File: rtl/pacman_pkg.sv
`default_nettype none

`include "pacman_config.svh"

package pacman_pkg;

	// ==============================
	// Heading of the sprite
	// ==============================
	typedef enum logic [1:0]
	{
		HEAD_RIGHT,
		HEAD_LEFT,
		HEAD_DOWN,
		HEAD_UP
	} heading_t;

	// One flag per direction; used for tilt, limits and heading
	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
	} dir_flags_t;

	// Sprite corner or centre position
	typedef struct packed
	{
		logic [`H_WIDTH-1:0] h;
		logic [`V_WIDTH-1:0] v;
	} sprite_pos_t;

	// Screen counters
	typedef struct packed
	{
		logic [`H_WIDTH-1:0] h;
		logic [`V_WIDTH-1:0] v;
	} raster_pos_t;

	typedef logic [7:0] pixel_t;   // 8-bit RGB

endpackage

`default_nettype wire

// File: rtl/sprite_window.sv
`timescale 1ns/100ps
`default_nettype none

`include "pacman_config.svh"

module sprite_window
(
	input  wire pacman_pkg::raster_pos_t raster,     // Screen counters
	input  wire pacman_pkg::sprite_pos_t pos,        // Sprite corner
	input  wire                          end_of_game,
	output logic                         pacman_en,
	output pacman_pkg::pixel_t           pacman_pixel
);

	localparam int HW = `H_WIDTH;
	localparam int VW = `V_WIDTH;

	localparam logic [HW-1:0] H_SIZE = HW'(`H_SPRITE_SIZE);
	localparam logic [VW-1:0] V_SIZE = VW'(`V_SPRITE_SIZE);

	logic [HW-1:0] h_far;      // Far edge, exclusive
	logic [VW-1:0] v_far;
	logic          h_inside;
	logic          v_inside;

	assign h_far = pos.h + H_SIZE;
	assign v_far = pos.v + V_SIZE;

	// Strict on both sides
	assign h_inside  = (raster.h > pos.h) && (raster.h < h_far);
	assign v_inside  = (raster.v > pos.v) && (raster.v < v_far);
	assign pacman_en = h_inside && v_inside;

	// Blank once the game is over
	assign pacman_pixel = (pacman_en && !end_of_game) ? `SPRITE_COLOUR : 8'h00;

endmodule

`default_nettype wire

// File: rtl/tilt_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module tilt_decoder
(
	input  wire                     clk,
	input  wire                     reset,
	input  wire [15:0]              x_axis,    // Accelerometer x sample
	input  wire [15:0]              y_axis,    // Accelerometer y sample
	output pacman_pkg::dir_flags_t  tilt
);

	logic x_active;
	logic y_active;

	// Axis counts as tilted on a large enough magnitude nibble
	function automatic logic axis_active(input logic [15:0] axis);
		return (axis[11:8] == 4'h1) || (axis[7:4] > 4'h4);
	endfunction

	assign x_active = axis_active(x_axis);
	assign y_active = axis_active(y_axis);

	// ==============================
	// Registered requests
	// ==============================
	// Sign nibble picks one side, so each pair never rises together
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tilt <= '0;
		end
		else
		begin
			tilt.up    <= x_active && (x_axis[15:12] == 4'h0);
			tilt.down  <= x_active && (x_axis[15:12] != 4'h0);
			tilt.right <= y_active && (y_axis[15:12] == 4'hf);
			tilt.left  <= y_active && (y_axis[15:12] != 4'hf);
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

TOP=pacman_controller_tb
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module "$TOP" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
	exit 0
fi
exit 1

// File: tb/pacman_controller_properties.sv
`timescale 1ns/100ps
`default_nettype none

`include "pacman_config.svh"

module pacman_controller_properties
(
	input wire                          clk,
	input wire                          reset,
	input wire                          hz_enable,
	input wire                          pause,
	input wire                          stall,
	input wire                          pacman_dead,
	input wire                          end_of_game,
	input wire pacman_pkg::dir_flags_t  heading_onehot,
	input wire pacman_pkg::sprite_pos_t tile_center
);

	import pacman_pkg::*;

	localparam logic [`H_WIDTH-1:0] H_OFF = `H_WIDTH'(`TILE_CENTER_OFFSET);
	localparam logic [`H_WIDTH-1:0] H_MIN = `H_WIDTH'(`H_BOARD_ON);
	localparam logic [`H_WIDTH-1:0] H_MAX = `H_WIDTH'(`H_BOARD_OFF - `H_SPRITE_SIZE);

	// Centre of the sprite at its start corner
	localparam logic [20:0] START_CENTER =
		{`H_WIDTH'(`H_START + `TILE_CENTER_OFFSET), `V_WIDTH'(`V_START + `TILE_CENTER_OFFSET)};

	logic [3:0]          heading_bits;
	logic [20:0]         center_bits;
	logic [`H_WIDTH-1:0] corner_h;     // Sprite corner column
	logic                no_step;

	assign heading_bits = heading_onehot;
	assign center_bits  = tile_center;
	assign corner_h     = tile_center.h - H_OFF;
	assign no_step      = !(hz_enable && !pause && !stall) && !pacman_dead && !end_of_game;

	// Death or game over sends the sprite back to start, heading right
	restart_state: assert property (@(posedge clk) disable iff (reset)
		(pacman_dead || end_of_game) |=> (heading_bits == 4'b0001)
		&& (center_bits == START_CENTER))
		else $error("sprite not back at start heading right after a restart");

	position_held: assert property (@(posedge clk) disable iff (reset)
		no_step |=> $stable(center_bits))
		else $error("sprite position changed on a clock without a step");

	// Tunnel wrap keeps the column on the board
	inside_board: assert property (@(posedge clk) disable iff (reset)
		(corner_h >= H_MIN) && (corner_h <= H_MAX))
		else $error("sprite column %0d is off the board", corner_h);

endmodule

bind pacman_controller pacman_controller_properties pacman_controller_properties_inst
(
	.clk            (clk),
	.reset          (reset),
	.hz_enable      (hz_enable),
	.pause          (pause),
	.stall          (stall),
	.pacman_dead    (pacman_dead),
	.end_of_game    (end_of_game),
	.heading_onehot (heading_onehot),
	.tile_center    (tile_center)
);

`default_nettype wire

// File: tb/pacman_controller_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pacman_config.svh"

module pacman_controller_tb;

	import pacman_pkg::*;

	localparam int CYCLE_LIMIT  = 8000;    // About twice the scheduled tests
	localparam int RANDOM_STEPS = 2000;

	localparam logic [`H_WIDTH-1:0] H_START_POS = `H_WIDTH'(`H_START);
	localparam logic [`V_WIDTH-1:0] V_START_POS = `V_WIDTH'(`V_START);
	localparam logic [`V_WIDTH-1:0] V_TUNNEL    = `V_WIDTH'(`V_START - `TUNNEL_ROW_OFFSET);
	localparam logic [`H_WIDTH-1:0] H_OFF       = `H_WIDTH'(`TILE_CENTER_OFFSET);
	localparam logic [`V_WIDTH-1:0] V_OFF       = `V_WIDTH'(`TILE_CENTER_OFFSET);

	typedef struct packed
	{
		heading_t    heading;
		sprite_pos_t pos;
	} model_t;

	logic        clk;
	logic        reset;
	logic [15:0] x_axis;
	logic [15:0] y_axis;
	logic        pause;
	logic        stall;
	logic        hz_enable;
	logic        pacman_dead;
	logic        end_of_game;
	dir_flags_t  limits;
	raster_pos_t raster;
	dir_flags_t  heading_onehot;
	sprite_pos_t tile_center;
	logic        pacman_en;
	logic        waka;
	pixel_t      pacman_pixel;

	logic [31:0] lfsr;
	model_t      model;
	dir_flags_t  model_tilt;          // Tilt register of the model
	int          errors;
	int          flow_errors;         // Failures of the test flow itself
	int          checks;
	int          cycles;

	pacman_controller pacman_controller_inst
	(
		.clk            (clk),
		.reset          (reset),
		.x_axis         (x_axis),
		.y_axis         (y_axis),
		.pause          (pause),
		.stall          (stall),
		.hz_enable      (hz_enable),
		.pacman_dead    (pacman_dead),
		.end_of_game    (end_of_game),
		.limits         (limits),
		.raster         (raster),
		.heading_onehot (heading_onehot),
		.tile_center    (tile_center),
		.pacman_en      (pacman_en),
		.waka           (waka),
		.pacman_pixel   (pacman_pixel)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==============================
	// Reference model
	// ==============================
	function automatic logic flag_of(input dir_flags_t f, input heading_t h);
		case (h)
			HEAD_UP:   return f.up;
			HEAD_DOWN: return f.down;
			HEAD_LEFT: return f.left;
			default:   return f.right;
		endcase
	endfunction

	function automatic dir_flags_t onehot_of(input heading_t h);
		dir_flags_t f;
		f = '0;
		f.up    = (h == HEAD_UP);
		f.down  = (h == HEAD_DOWN);
		f.left  = (h == HEAD_LEFT);
		f.right = (h == HEAD_RIGHT);
		return f;
	endfunction

	function automatic dir_flags_t ref_tilt(input logic [15:0] x, input logic [15:0] y);
		dir_flags_t t;
		logic       x_on;
		logic       y_on;
		x_on    = (x[11:8] == 4'h1) || (x[7:4] > 4'h4);
		y_on    = (y[11:8] == 4'h1) || (y[7:4] > 4'h4);
		t.up    = x_on && (x[15:12] == 4'h0);
		t.down  = x_on && (x[15:12] != 4'h0);
		t.right = y_on && (y[15:12] == 4'hf);
		t.left  = y_on && (y[15:12] != 4'hf);
		return t;
	endfunction

	// True when the sprite would move; new_head is where it would go
	function automatic logic plan_move(input model_t s, input dir_flags_t tilt,
		input dir_flags_t lim, output heading_t new_head);
		heading_t order [4];
		logic     found;
		order[0] = HEAD_UP;
		order[1] = HEAD_DOWN;
		order[2] = HEAD_LEFT;
		order[3] = HEAD_RIGHT;
		found    = 1'b0;
		new_head = s.heading;
		for (int i = 0; i < 4; i++)
		begin
			if (!found && order[i] != s.heading && flag_of(tilt, order[i])
				&& flag_of(lim, order[i]))
			begin
				new_head = order[i];
				found    = 1'b1;
			end
		end
		return found || flag_of(lim, s.heading);
	endfunction

	function automatic model_t ref_step(input model_t s, input dir_flags_t tilt,
		input dir_flags_t lim);
		model_t   n;
		heading_t h;
		n = s;
		if (plan_move(s, tilt, lim, h))
		begin
			n.heading = h;
			case (h)
				HEAD_UP:   n.pos.v = s.pos.v - 1'b1;
				HEAD_DOWN: n.pos.v = s.pos.v + 1'b1;
				HEAD_LEFT:
				begin
					if (s.pos.h == `H_WIDTH'(`H_BOARD_ON))    // Into the tunnel
					begin
						n.pos.h = `H_WIDTH'(`H_BOARD_OFF - 1 - `H_SPRITE_SIZE);
						n.pos.v = V_TUNNEL;
					end
					else
						n.pos.h = s.pos.h - 1'b1;
				end
				HEAD_RIGHT:
				begin
					if (s.pos.h == `H_WIDTH'(`H_BOARD_OFF - `H_SPRITE_SIZE))
					begin
						n.pos.h = `H_WIDTH'(`H_BOARD_ON + 1);
						n.pos.v = V_TUNNEL;
					end
					else
						n.pos.h = s.pos.h + 1'b1;
				end
			endcase
		end
		return n;
	endfunction

	function automatic logic window_hit(input raster_pos_t r, input sprite_pos_t p);
		logic [`H_WIDTH-1:0] h_end;
		logic [`V_WIDTH-1:0] v_end;
		h_end = p.h + `H_WIDTH'(`H_SPRITE_SIZE);
		v_end = p.v + `V_WIDTH'(`V_SPRITE_SIZE);
		return (r.h > p.h) && (r.h < h_end) && (r.v > p.v) && (r.v < v_end);
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// ==============================
	// Checks
	// ==============================
	task automatic check_dirs(input string name, input dir_flags_t got, input dir_flags_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_pos(input string name, input sprite_pos_t got, input sprite_pos_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s got h=%0d v=%0d expected h=%0d v=%0d",
				$time, name, got.h, got.v, exp.h, exp.v);
		end
	endtask

	task automatic check_bit(input string name, input pixel_t got, input pixel_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_outputs();
		sprite_pos_t exp_center;
		heading_t    unused_head;
		logic        exp_en;
		logic        exp_waka;
		pixel_t      exp_pixel;
		exp_center.h = model.pos.h + H_OFF;
		exp_center.v = model.pos.v + V_OFF;
		exp_waka     = plan_move(model, model_tilt, limits, unused_head);
		exp_en       = window_hit(raster, model.pos);
		exp_pixel    = (exp_en && !end_of_game) ? `SPRITE_COLOUR : 8'h00;
		check_dirs("heading_onehot", heading_onehot, onehot_of(model.heading));
		check_pos("tile_center", tile_center, exp_center);
		check_bit("waka", pixel_t'(waka), pixel_t'(exp_waka));
		check_bit("pacman_en", pixel_t'(pacman_en), pixel_t'(exp_en));
		check_bit("pacman_pixel", pacman_pixel, exp_pixel);
	endtask

	// Model follows the DUT clock, outputs checked mid high phase
	always @(posedge clk)
	begin
		if (reset)
		begin
			model.heading = HEAD_RIGHT;
			model.pos.h   = H_START_POS;
			model.pos.v   = V_START_POS;
			model_tilt    = '0;
		end
		else
		begin
			if (pacman_dead || end_of_game)
			begin
				model.heading = HEAD_RIGHT;
				model.pos.h   = H_START_POS;
				model.pos.v   = V_START_POS;
			end
			else if (hz_enable && !pause && !stall)
				model = ref_step(model, model_tilt, limits);
			model_tilt = ref_tilt(x_axis, y_axis);   // Old tilt used above
		end
		#5;
		if (!reset)
			compare_outputs();
	end

	// ==============================
	// Stimulus
	// ==============================
	task automatic run_to_tunnel();
		int n;
		n = 0;
		@(negedge clk);
		hz_enable = 1'b1;
		limits    = '1;
		while (tile_center.v != V_TUNNEL + V_OFF && n < 400)
		begin
			@(negedge clk);
			n++;
		end
		if (n >= 400)
		begin
			flow_errors++;
			$display("the sprite never reached the tunnel row while moving right");
		end
		repeat (10) @(negedge clk);   // Keep going along the tunnel row
		hz_enable = 1'b0;
	endtask

	task automatic restart_sprite(input logic by_death);
		@(negedge clk);
		hz_enable   = 1'b1;    // Step on the same clock must lose
		limits      = '1;
		pacman_dead = by_death;
		end_of_game = !by_death;
		@(negedge clk);
		pacman_dead = 1'b0;
		end_of_game = 1'b0;
		hz_enable   = 1'b0;
	endtask

	task automatic random_steps(input int count);
		logic [15:0] bits;
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk);
			bits        = take_bits(12);
			x_axis      = {(take_bits(1) != 16'd0) ? 4'hf : 4'h0, bits[11:0]};
			bits        = take_bits(12);
			y_axis      = {(take_bits(1) != 16'd0) ? 4'hf : 4'h0, bits[11:0]};
			bits        = take_bits(4);
			limits      = bits[3:0];
			hz_enable   = (take_bits(1) != 16'd0);
			pause       = (take_bits(3) == 16'd0);
			stall       = (take_bits(3) == 16'd0);
			pacman_dead = (take_bits(7) == 16'd0);
			bits        = take_bits(6);
			raster.h    = model.pos.h + `H_WIDTH'(bits[5:0]) - `H_WIDTH'(12);
			bits        = take_bits(6);
			raster.v    = model.pos.v + `V_WIDTH'(bits[5:0]) - `V_WIDTH'(12);
		end
		@(negedge clk);
		pause       = 1'b0;
		stall       = 1'b0;
		pacman_dead = 1'b0;
		hz_enable   = 1'b0;
	endtask

	// Strobes under pause, then under stall, with an open up request
	task automatic held_steps(input int count);
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk);
			hz_enable = 1'b1;
			x_axis    = 16'h0050;
			limits    = '1;
			pause     = (i < count / 2);
			stall     = (i >= count / 2);
		end
		@(negedge clk);
		pause     = 1'b0;
		stall     = 1'b0;
		hz_enable = 1'b0;
		x_axis    = '0;
	endtask

	task automatic sweep_window();
		logic [15:0] bits;
		for (int v = -2; v <= `V_SPRITE_SIZE + 2; v++)
		begin
			for (int h = -2; h <= `H_SPRITE_SIZE + 2; h++)
			begin
				@(negedge clk);
				hz_enable   = 1'b0;
				bits        = take_bits(1);
				end_of_game = bits[0];    // Blanks pixel, keeps sprite at start
				raster.h    = H_START_POS + `H_WIDTH'(h);
				raster.v    = V_START_POS + `V_WIDTH'(v);
			end
		end
		@(negedge clk);
		end_of_game = 1'b0;
	endtask

	initial
	begin
		lfsr        = 32'h279f_5222;
		errors      = 0;
		flow_errors = 0;
		checks      = 0;
		reset       = 1'b1;
		x_axis      = '0;
		y_axis      = '0;
		pause       = 1'b0;
		stall       = 1'b0;
		hz_enable   = 1'b0;
		pacman_dead = 1'b0;
		end_of_game = 1'b0;
		limits      = '1;
		raster      = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);

		run_to_tunnel();
		restart_sprite(1'b1);
		random_steps(RANDOM_STEPS);
		held_steps(40);
		restart_sprite(1'b1);
		restart_sprite(1'b0);
		sweep_window();
		repeat (4) @(negedge clk);

		$display("%0d checks, %0d errors", checks, errors + flow_errors);
		if (errors == 0 && flow_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Run limit
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
